/* battle_cfg.svh */
`ifndef BATTLE_CFG_SVH
`define BATTLE_CFG_SVH

// slots per side
`define SLOTS_PER_SIDE 4

// field geometry
`define ENEMY_TOWER_X 10'd65
`define ARMY_TOWER_X  10'd570
`define ENEMY_SPAWN_X 10'd10
`define ARMY_SPAWN_X  10'd570

// limits
`define TOWER_HP_MAX   12'd1000
`define MONEY_MAX      15'd200
`define MONEY_PER_TICK 15'd2

// enemy schedule, in game ticks
`define SCHED_TICK_0 8'd8
`define SCHED_TICK_1 8'd24
`define SCHED_TICK_2 8'd40
`define SCHED_TICK_3 8'd56

`endif

/* battle_pkg.sv */
package battle_pkg;

    typedef logic [9:0]  pos_t;
    typedef logic [11:0] hp_t;
    typedef logic [14:0] money_t;

    typedef enum logic [1:0] {
        kind_bird       = 2'd0,  // enemy
        kind_white_bear = 2'd1,  // ally
        kind_duck       = 2'd2,  // enemy
        kind_black_bear = 2'd3   // ally
    } unit_kind_t;

    typedef enum logic [1:0] {
        st_move    = 2'd0,
        st_windup  = 2'd1,
        st_strike  = 2'd2,
        st_recover = 2'd3
    } unit_state_t;

    typedef struct packed {
        hp_t        hp;
        logic [7:0] atk;
        logic [3:0] cooldown;  // ticks in windup and in recover
        logic [3:0] speed;     // x per tick
        logic [7:0] range;
        money_t     cost;      // 0 for enemy kinds
    } unit_stats_t;

    typedef struct packed {
        logic        alive;
        unit_kind_t  kind;
        pos_t        x;
        hp_t         hp;
        unit_state_t state;
        logic [3:0]  state_cnt;
    } unit_t;

    function automatic unit_stats_t unit_stats(input unit_kind_t kind);
        unit_stats_t s;
        s = '0;
        case (kind)
            //                    hp      atk    cd    spd   range  cost
            kind_bird:       s = '{12'd40, 8'd10, 4'd3, 4'd4, 8'd20, 15'd0};
            kind_duck:       s = '{12'd80, 8'd25, 4'd5, 4'd2, 8'd30, 15'd0};
            kind_white_bear: s = '{12'd60, 8'd15, 4'd3, 4'd3, 8'd25, 15'd30};
            kind_black_bear: s = '{12'd120, 8'd40, 4'd6, 4'd2, 8'd35, 15'd75};
            default:         s = '0;
        endcase
        return s;
    endfunction

endpackage

/* unit_if.sv */
interface unit_if
    import battle_pkg::*;
();
    logic       load;         // one-cycle spawn pulse
    unit_kind_t load_kind;
    logic       alive;
    pos_t       x;
    hp_t        strike_dmg;   // nonzero during st_strike
    logic       front_ok;     // may be targeted as front unit
    pos_t       opp_front_x;  // opposing front unit or tower
    hp_t        hit_dmg;

    modport slot (
        input  load, load_kind, opp_front_x, hit_dmg,
        output alive, x, strike_dmg, front_ok
    );

    modport spawner (
        input  alive,
        output load, load_kind
    );

    modport resolver (
        input  alive, x, strike_dmg, front_ok,
        output opp_front_x, hit_dmg
    );

endinterface

/* unit_slot.sv */
`include "battle_cfg.svh"

module unit_slot
    import battle_pkg::*;
#(
    parameter bit IS_ARMY = 1'b0
) (
    input  logic clk_25MHz,
    input  logic rst,
    input  logic tick,
    input  logic game_over,
    unit_if.slot u
);

    unit_t       unit;
    unit_stats_t st;
    unit_stats_t load_st;
    logic        in_range;
    pos_t        step_x;

    assign st      = unit_stats(unit.kind);
    assign load_st = unit_stats(u.load_kind);

    // ------------------------------
    // range and walk
    always_comb begin
        if (IS_ARMY) begin
            // allies walk left toward the enemy tower
            in_range = unit.x <= u.opp_front_x + pos_t'(st.range);
            if (unit.x >= `ENEMY_TOWER_X + pos_t'(st.speed))
                step_x = unit.x - pos_t'(st.speed);
            else
                step_x = `ENEMY_TOWER_X;
        end else begin
            in_range = unit.x + pos_t'(st.range) >= u.opp_front_x;
            if (unit.x + pos_t'(st.speed) <= `ARMY_TOWER_X)
                step_x = unit.x + pos_t'(st.speed);
            else
                step_x = `ARMY_TOWER_X;
        end
    end

    // ------------------------------
    // unit state
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            unit.alive     <= 1'b0;
            unit.state     <= st_move;
            unit.state_cnt <= '0;
        end else if (u.load) begin
            unit.alive     <= 1'b1;
            unit.kind      <= u.load_kind;
            unit.x         <= IS_ARMY ? `ARMY_SPAWN_X : `ENEMY_SPAWN_X;
            unit.hp        <= load_st.hp;
            unit.state     <= st_move;
            unit.state_cnt <= '0;
        end else if (tick && !game_over && unit.alive) begin
            if (u.hit_dmg >= unit.hp) begin
                unit.alive <= 1'b0;  // killed
            end else begin
                unit.hp <= unit.hp - u.hit_dmg;
                case (unit.state)
                    st_move: begin
                        if (in_range) begin
                            unit.state     <= st_windup;
                            unit.state_cnt <= '0;
                        end else begin
                            unit.x <= step_x;
                        end
                    end
                    st_windup: begin
                        if (unit.state_cnt + 4'd1 == st.cooldown) begin
                            unit.state     <= st_strike;
                            unit.state_cnt <= '0;
                        end else begin
                            unit.state_cnt <= unit.state_cnt + 4'd1;
                        end
                    end
                    st_strike: begin
                        unit.state     <= st_recover;
                        unit.state_cnt <= '0;
                    end
                    default: begin  // recover
                        if (unit.state_cnt + 4'd1 == st.cooldown) begin
                            unit.state     <= st_move;
                            unit.state_cnt <= '0;
                        end else begin
                            unit.state_cnt <= unit.state_cnt + 4'd1;
                        end
                    end
                endcase
            end
        end
    end

    assign u.alive      = unit.alive;
    assign u.x          = unit.x;
    assign u.strike_dmg = (unit.alive && unit.state == st_strike && in_range) ?
                          hp_t'(st.atk) : '0;
    // a unit about to die from damage in flight is skipped as front
    assign u.front_ok   = unit.alive && (u.hit_dmg < unit.hp);

    a_no_load_alive: assert property (@(posedge clk_25MHz) disable iff (rst)
        u.load |-> !unit.alive);

    a_x_on_field: assert property (@(posedge clk_25MHz) disable iff (rst)
        unit.alive |-> (unit.x >= `ENEMY_SPAWN_X && unit.x <= `ARMY_TOWER_X));

endmodule

/* unit_spawner.sv */
`include "battle_cfg.svh"

module unit_spawner
    import battle_pkg::*;
(
    input  logic       clk_25MHz,
    input  logic       rst,
    input  logic       tick,
    input  logic       game_over,
    input  logic       deploy_req,
    input  unit_kind_t deploy_kind,
    output logic       deploy_ack,
    output logic       deploy_granted,
    input  money_t     money,
    output money_t     charge,
    unit_if.spawner    enemy_slots [`SLOTS_PER_SIDE],
    unit_if.spawner    army_slots [`SLOTS_PER_SIDE]
);

    localparam int N = `SLOTS_PER_SIDE;

    typedef enum logic [1:0] {
        s_idle,
        s_decide,
        s_ack,
        s_wait
    } dep_state_t;

    dep_state_t  dep_state;
    logic [7:0]  game_tick;
    logic        sched_hit;
    unit_kind_t  sched_kind;
    logic [N-1:0] enemy_free;
    logic [N-1:0] army_free;
    logic [N-1:0] enemy_load;
    logic [N-1:0] army_load;
    logic        grant;
    logic        granted_q;
    unit_stats_t dep_st;

    generate
        for (genvar i = 0; i < N; i++) begin : g_port
            assign enemy_free[i]            = !enemy_slots[i].alive;
            assign army_free[i]             = !army_slots[i].alive;
            assign enemy_slots[i].load      = enemy_load[i];
            assign enemy_slots[i].load_kind = sched_kind;
            assign army_slots[i].load       = army_load[i];
            assign army_slots[i].load_kind  = deploy_kind;
        end
    endgenerate

    // ------------------------------
    // enemy schedule
    always_ff @(posedge clk_25MHz) begin
        if (rst)
            game_tick <= '0;
        else if (tick && !game_over && game_tick != 8'hff)
            game_tick <= game_tick + 8'd1;
    end

    always_comb begin
        sched_hit  = 1'b1;
        sched_kind = kind_bird;
        case (game_tick)
            `SCHED_TICK_0, `SCHED_TICK_2: sched_kind = kind_bird;
            `SCHED_TICK_1, `SCHED_TICK_3: sched_kind = kind_duck;
            default: sched_hit = 1'b0;
        endcase
    end

    // lowest free slot, skipped when none
    assign enemy_load = (tick && !game_over && sched_hit) ?
                        enemy_free & (~enemy_free + 1'b1) : '0;

    // ------------------------------
    // deploy handshake
    assign dep_st = unit_stats(deploy_kind);

    // enemy kinds carry no cost and cannot be bought
    assign grant = (dep_state == s_decide) && !game_over && (dep_st.cost != '0) &&
                   (money >= dep_st.cost) && (|army_free);

    assign charge    = grant ? dep_st.cost : '0;
    assign army_load = grant ? army_free & (~army_free + 1'b1) : '0;

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            dep_state <= s_idle;
            granted_q <= 1'b0;
        end else begin
            case (dep_state)
                s_idle: begin
                    if (deploy_req)
                        dep_state <= s_decide;
                end
                s_decide: begin
                    granted_q <= grant;
                    dep_state <= s_ack;
                end
                s_ack: dep_state <= deploy_req ? s_wait : s_idle;
                default: begin  // hold ack until release
                    if (!deploy_req)
                        dep_state <= s_idle;
                end
            endcase
        end
    end

    assign deploy_ack     = (dep_state == s_ack) || (dep_state == s_wait);
    assign deploy_granted = deploy_ack && granted_q;

    a_ack_after_req: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(deploy_ack) |-> $past(deploy_req, 2));

    a_one_load: assert property (@(posedge clk_25MHz) disable iff (rst)
        $onehot0(enemy_load) && $onehot0(army_load));

endmodule

/* battle_resolver.sv */
`include "battle_cfg.svh"

module battle_resolver
    import battle_pkg::*;
(
    input  logic       clk_25MHz,
    input  logic       rst,
    input  logic       tick,
    unit_if.resolver   enemy_slots [`SLOTS_PER_SIDE],
    unit_if.resolver   army_slots [`SLOTS_PER_SIDE],
    output hp_t        tower_hp_enemy,
    output hp_t        tower_hp_army,
    output logic       game_win,
    output logic       game_lose,
    output logic       game_over,
    output logic [2:0] enemy_count,
    output logic [2:0] army_count
);

    localparam int N = `SLOTS_PER_SIDE;

    logic [N-1:0] e_alive;
    logic [N-1:0] a_alive;
    logic [N-1:0] e_ok;
    logic [N-1:0] a_ok;
    pos_t         e_x [N];
    pos_t         a_x [N];
    hp_t          e_strike [N];
    hp_t          a_strike [N];
    logic         e_front_any;
    logic         a_front_any;
    pos_t         e_front_x;
    pos_t         a_front_x;
    logic [N-1:0] e_front_sel;
    logic [N-1:0] a_front_sel;
    hp_t          e_sum;
    hp_t          a_sum;
    logic         tick_d;
    hp_t          e_pend_dmg;  // army strikes waiting for an enemy
    hp_t          a_pend_dmg;
    logic [N-1:0] e_pend_sel;
    logic [N-1:0] a_pend_sel;

    generate
        for (genvar i = 0; i < N; i++) begin : g_port
            assign e_alive[i]  = enemy_slots[i].alive;
            assign e_ok[i]     = enemy_slots[i].front_ok;
            assign e_x[i]      = enemy_slots[i].x;
            assign e_strike[i] = enemy_slots[i].strike_dmg;
            assign a_alive[i]  = army_slots[i].alive;
            assign a_ok[i]     = army_slots[i].front_ok;
            assign a_x[i]      = army_slots[i].x;
            assign a_strike[i] = army_slots[i].strike_dmg;

            assign enemy_slots[i].opp_front_x = a_front_x;
            assign army_slots[i].opp_front_x  = e_front_x;
            assign enemy_slots[i].hit_dmg     = e_pend_sel[i] ? e_pend_dmg : '0;
            assign army_slots[i].hit_dmg      = a_pend_sel[i] ? a_pend_dmg : '0;
        end
    endgenerate

    // ------------------------------
    // front lines and strike sums
    always_comb begin
        e_front_any = 1'b0;
        e_front_x   = `ENEMY_TOWER_X;  // tower when no enemy stands
        e_front_sel = '0;
        a_front_any = 1'b0;
        a_front_x   = `ARMY_TOWER_X;
        a_front_sel = '0;
        e_sum       = '0;
        a_sum       = '0;
        for (int i = 0; i < N; i++) begin
            // enemies march right, so their front has the largest x
            if (e_ok[i] && (!e_front_any || e_x[i] > e_front_x)) begin
                e_front_any    = 1'b1;
                e_front_x      = e_x[i];
                e_front_sel    = '0;
                e_front_sel[i] = 1'b1;
            end
            if (a_ok[i] && (!a_front_any || a_x[i] < a_front_x)) begin
                a_front_any    = 1'b1;
                a_front_x      = a_x[i];
                a_front_sel    = '0;
                a_front_sel[i] = 1'b1;
            end
            e_sum = e_sum + e_strike[i];
            a_sum = a_sum + a_strike[i];
        end
    end

    // ------------------------------
    // damage routing, towers, result
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            tick_d         <= 1'b0;
            e_pend_sel     <= '0;
            a_pend_sel     <= '0;
            tower_hp_enemy <= `TOWER_HP_MAX;
            tower_hp_army  <= `TOWER_HP_MAX;
            game_win       <= 1'b0;
            game_lose      <= 1'b0;
        end else begin
            tick_d <= tick && !game_over;
            if (tick) begin  // slots consume pending damage on this tick
                e_pend_sel <= '0;
                a_pend_sel <= '0;
            end
            if (tick_d) begin
                if (e_front_any) begin
                    e_pend_dmg <= a_sum;
                    e_pend_sel <= e_front_sel;
                end else begin
                    tower_hp_enemy <= (a_sum >= tower_hp_enemy) ? '0 : tower_hp_enemy - a_sum;
                end
                if (a_front_any) begin
                    a_pend_dmg <= e_sum;
                    a_pend_sel <= a_front_sel;
                end else begin
                    tower_hp_army <= (e_sum >= tower_hp_army) ? '0 : tower_hp_army - e_sum;
                end
            end
            if (tower_hp_enemy == '0)
                game_win <= 1'b1;
            if (tower_hp_army == '0)
                game_lose <= 1'b1;
        end
    end

    assign game_over   = game_win || game_lose;
    assign enemy_count = 3'($countones(e_alive));
    assign army_count  = 3'($countones(a_alive));

endmodule

/* wallet.sv */
`include "battle_cfg.svh"

module wallet
    import battle_pkg::*;
(
    input  logic   clk_25MHz,
    input  logic   rst,
    input  logic   tick,
    input  logic   game_over,
    input  money_t charge,
    output money_t money
);

    money_t income;
    money_t next_money;

    assign income = (tick && !game_over) ? `MONEY_PER_TICK : '0;

    always_comb begin
        // charge never exceeds money, the spawner checks before granting
        next_money = money - charge + income;
        if (next_money > `MONEY_MAX)
            next_money = `MONEY_MAX;  // cap
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst)
            money <= '0;
        else
            money <= next_money;
    end

    a_money_cap: assert property (@(posedge clk_25MHz) disable iff (rst)
        money <= `MONEY_MAX);

    // a grant never overdraws
    a_charge_covered: assert property (@(posedge clk_25MHz) disable iff (rst)
        charge <= money);

endmodule

/* battle_top.sv */
`include "battle_cfg.svh"

module battle_top
    import battle_pkg::*;
(
    input  logic       clk_25MHz,
    input  logic       rst,
    input  logic       tick,
    input  logic       deploy_req,
    input  unit_kind_t deploy_kind,
    output logic       deploy_ack,
    output logic       deploy_granted,
    output money_t     money,
    output logic [2:0] enemy_count,
    output logic [2:0] army_count,
    output hp_t        tower_hp_enemy,
    output hp_t        tower_hp_army,
    output logic       game_win,
    output logic       game_lose
);

    money_t charge;
    logic   game_over;

    unit_if enemy_if [`SLOTS_PER_SIDE] ();
    unit_if army_if [`SLOTS_PER_SIDE] ();

    // ------------------------------
    // unit slots, one loop per side
    generate
        for (genvar i = 0; i < `SLOTS_PER_SIDE; i++) begin : g_enemy
            unit_slot #(
                .IS_ARMY (1'b0)
            ) u_slot (
                .clk_25MHz (clk_25MHz),
                .rst       (rst),
                .tick      (tick),
                .game_over (game_over),
                .u         (enemy_if[i])
            );
        end
        for (genvar i = 0; i < `SLOTS_PER_SIDE; i++) begin : g_army
            unit_slot #(
                .IS_ARMY (1'b1)
            ) u_slot (
                .clk_25MHz (clk_25MHz),
                .rst       (rst),
                .tick      (tick),
                .game_over (game_over),
                .u         (army_if[i])
            );
        end
    endgenerate

    unit_spawner u_spawner (
        .clk_25MHz      (clk_25MHz),
        .rst            (rst),
        .tick           (tick),
        .game_over      (game_over),
        .deploy_req     (deploy_req),
        .deploy_kind    (deploy_kind),
        .deploy_ack     (deploy_ack),
        .deploy_granted (deploy_granted),
        .money          (money),
        .charge         (charge),
        .enemy_slots    (enemy_if),
        .army_slots     (army_if)
    );

    wallet u_wallet (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .tick      (tick),
        .game_over (game_over),
        .charge    (charge),
        .money     (money)
    );

    battle_resolver u_resolver (
        .clk_25MHz      (clk_25MHz),
        .rst            (rst),
        .tick           (tick),
        .enemy_slots    (enemy_if),
        .army_slots     (army_if),
        .tower_hp_enemy (tower_hp_enemy),
        .tower_hp_army  (tower_hp_army),
        .game_win       (game_win),
        .game_lose      (game_lose),
        .game_over      (game_over),
        .enemy_count    (enemy_count),
        .army_count     (army_count)
    );

endmodule

/* tb_battle_top.sv */
`include "battle_cfg.svh"

module tb_battle_top
    import battle_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS       = 40;
    localparam int CYC_PER_TICK = 4;
    localparam int RST_CYCLES   = 5;
    localparam int HS_TIMEOUT   = 10;    // cycles per handshake phase
    localparam int HS_CYCLES    = 24;    // budget per table row
    localparam int PUSH_TICKS   = 1500;  // bound on the allied push
    localparam int HOLD_TICKS   = 5;
    localparam int COST_WHITE   = 30;
    localparam int COST_BLACK   = 75;
    localparam int ATK_WHITE    = 15;
    localparam int ATK_BLACK    = 40;

    typedef struct packed {
        int         ticks;        // ticks run before the deploy
        logic       deploy;
        unit_kind_t kind;
        logic       exp_granted;
        int         exp_army;
    } row_t;

    logic       clk_25MHz;
    logic       rst;
    logic       tick;
    logic       deploy_req;
    unit_kind_t deploy_kind;
    logic       deploy_ack;
    logic       deploy_granted;
    money_t     money;
    logic [2:0] enemy_count;
    logic [2:0] army_count;
    hp_t        tower_hp_enemy;
    hp_t        tower_hp_army;
    logic       game_win;
    logic       game_lose;

    row_t   rows [$];
    int     model_money;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    longint watchdog_ns;

    battle_top dut0 (
        .clk_25MHz      (clk_25MHz),
        .rst            (rst),
        .tick           (tick),
        .deploy_req     (deploy_req),
        .deploy_kind    (deploy_kind),
        .deploy_ack     (deploy_ack),
        .deploy_granted (deploy_granted),
        .money          (money),
        .enemy_count    (enemy_count),
        .army_count     (army_count),
        .tower_hp_enemy (tower_hp_enemy),
        .tower_hp_army  (tower_hp_army),
        .game_win       (game_win),
        .game_lose      (game_lose)
    );

    initial begin
        clk_25MHz = 1'b0;
        forever #(CLK_NS / 2) clk_25MHz = ~clk_25MHz;
    end

    // ------------------------------
    // helpers
    function automatic int cost_of(input unit_kind_t kind);
        case (kind)
            kind_white_bear: return COST_WHITE;
            kind_black_bear: return COST_BLACK;
            default:         return 0;
        endcase
    endfunction

    // any mix of up to three white bears and one black bear
    function automatic bit step_is_legal(input int drop, input int new_hp);
        int s;
        for (int a = 0; a <= 3; a++) begin
            for (int b = 0; b <= 1; b++) begin
                s = a * ATK_WHITE + b * ATK_BLACK;
                if (s > 0 && (s == drop || (new_hp == 0 && drop <= s)))
                    return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input int ticks, input logic deploy, input unit_kind_t kind,
                           input logic exp_granted, input int exp_army);
        row_t r;
        r.ticks       = ticks;
        r.deploy      = deploy;
        r.kind        = kind;
        r.exp_granted = exp_granted;
        r.exp_army    = exp_army;
        rows.push_back(r);
    endtask

    task automatic run_ticks(input int n);
        repeat (n) begin
            @(posedge clk_25MHz);
            #5;
            if (!(game_win || game_lose)) begin
                model_money = model_money + `MONEY_PER_TICK;
                if (model_money > `MONEY_MAX)
                    model_money = `MONEY_MAX;  // cap
            end
            tick = 1'b1;
            @(posedge clk_25MHz);
            #5;
            tick = 1'b0;
            repeat (2) @(posedge clk_25MHz);
        end
    endtask

    // four-phase request, returns the grant seen with ack
    task automatic deploy(input unit_kind_t kind, output logic granted);
        int wait_cyc;
        granted  = 1'b0;
        wait_cyc = 0;
        @(posedge clk_25MHz);
        #5;
        deploy_kind = kind;
        deploy_req  = 1'b1;
        @(negedge clk_25MHz);
        while (!deploy_ack && wait_cyc < HS_TIMEOUT) begin
            @(negedge clk_25MHz);
            wait_cyc++;
        end
        if (!deploy_ack) begin
            $display("deploy_ack never rose after the request, t=%0t", $time);
            errors++;
        end else begin
            check_val("deploy_ack latency", wait_cyc, 2);
            granted = deploy_granted;
        end
        @(posedge clk_25MHz);
        #5;
        deploy_req = 1'b0;
        wait_cyc   = 0;
        @(negedge clk_25MHz);
        while (deploy_ack && wait_cyc < HS_TIMEOUT) begin
            @(negedge clk_25MHz);
            wait_cyc++;
        end
        if (deploy_ack) begin
            $display("deploy_ack stayed high after the request fell, t=%0t", $time);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end
    endtask

    task automatic build_table();
        // money runs from 18 at the first spawn
        add_row(5,  1'b1, kind_white_bear, 1'b0, 0);  // 28, too poor
        add_row(10, 1'b1, kind_black_bear, 1'b0, 0);  // 48, too poor
        add_row(80, 1'b0, kind_white_bear, 1'b0, 0);  // reaches cap
        add_row(6,  1'b0, kind_white_bear, 1'b0, 0);  // held at cap
        add_row(0,  1'b1, kind_white_bear, 1'b1, 1);
        add_row(0,  1'b1, kind_black_bear, 1'b1, 2);
        add_row(0,  1'b1, kind_white_bear, 1'b1, 3);
        add_row(0,  1'b1, kind_white_bear, 1'b1, 4);
        add_row(0,  1'b1, kind_white_bear, 1'b0, 4);  // money ok, slots full
        add_row(3,  1'b0, kind_white_bear, 1'b0, 4);
    endtask

    // ------------------------------
    // watchdog
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("watchdog expired at t=%0t, run did not finish", $time);
        $display("Some tests failed");
        $finish;
    end

    initial begin : main
        logic granted;
        int   errs_before;
        int   total_ticks;
        int   prev_hp;
        int   drop;
        int   n;

        rst          = 1'b1;
        tick         = 1'b0;
        deploy_req   = 1'b0;
        deploy_kind  = kind_white_bear;
        model_money  = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        watchdog_ns  = 0;

        build_table();
        total_ticks = `SCHED_TICK_0 + 1 + PUSH_TICKS + HOLD_TICKS;
        foreach (rows[i])
            total_ticks += rows[i].ticks;
        watchdog_ns = longint'(total_ticks * CYC_PER_TICK + rows.size() * HS_CYCLES
                      + RST_CYCLES + 200) * CLK_NS;

        repeat (RST_CYCLES) @(posedge clk_25MHz);
        #5;
        rst = 1'b0;

        // reset values
        errs_before = errors;
        @(negedge clk_25MHz);
        check_val("money", money, 0);
        check_val("enemy_count", enemy_count, 0);
        check_val("army_count", army_count, 0);
        check_val("tower_hp_enemy", tower_hp_enemy, `TOWER_HP_MAX);
        check_val("tower_hp_army", tower_hp_army, `TOWER_HP_MAX);
        check_val("deploy_ack", deploy_ack, 0);
        check_val("deploy_granted", deploy_granted, 0);
        check_val("game_win", game_win, 0);
        check_val("game_lose", game_lose, 0);
        end_test("reset values", errs_before);

        // first scheduled enemy
        errs_before = errors;
        run_ticks(`SCHED_TICK_0);
        @(negedge clk_25MHz);
        check_val("enemy_count", enemy_count, 0);
        run_ticks(1);
        @(negedge clk_25MHz);
        check_val("enemy_count", enemy_count, 1);
        check_val("money", money, model_money);
        end_test("first enemy spawn", errs_before);

        for (int r = 0; r < rows.size(); r++) begin
            errs_before = errors;
            run_ticks(rows[r].ticks);
            if (rows[r].deploy) begin
                deploy(rows[r].kind, granted);
                check_val("deploy_granted", granted, rows[r].exp_granted);
                if (rows[r].exp_granted)
                    model_money = model_money - cost_of(rows[r].kind);
            end
            @(negedge clk_25MHz);
            check_val("money", money, model_money);
            check_val("army_count", army_count, rows[r].exp_army);
            end_test($sformatf("row %0d", r), errs_before);
        end

        // ------------------------------
        // allied push to the enemy tower
        errs_before = errors;
        n = 0;
        @(negedge clk_25MHz);
        prev_hp = tower_hp_enemy;
        while (!game_win && !game_lose && n < PUSH_TICKS) begin
            run_ticks(1);
            @(negedge clk_25MHz);
            if (tower_hp_enemy != prev_hp) begin
                drop = prev_hp - tower_hp_enemy;
                if (!step_is_legal(drop, tower_hp_enemy)) begin
                    $display("CHECK FAILED t=%0t tower_hp_enemy: got %0d expected %0d less a %s",
                             $time, tower_hp_enemy, prev_hp, "sum of 15 and 40 steps");
                    errors++;
                end
                prev_hp = tower_hp_enemy;
            end
            n++;
        end
        if (game_lose) begin
            $display("army tower fell before the enemy tower, t=%0t", $time);
            errors++;
        end else if (!game_win) begin
            $display("enemy tower still standing after %0d ticks", PUSH_TICKS);
            errors++;
        end else begin
            check_val("tower_hp_enemy", tower_hp_enemy, 0);
            check_val("money", money, model_money);
            run_ticks(HOLD_TICKS);
            @(negedge clk_25MHz);
            check_val("game_win", game_win, 1);
            check_val("game_lose", game_lose, 0);
            check_val("money", money, model_money);  // frozen after the win
        end
        end_test("allied push", errs_before);

        $display("tests: %0d passed, %0d failed, failed checks: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
battle_pkg.sv
unit_if.sv
unit_slot.sv
unit_spawner.sv
battle_resolver.sv
wallet.sv
battle_top.sv
tb_battle_top.sv

/* Bender.yml */
package:
  name: battle_core

sources:
  - include_dirs:
      - .
    files:
      - battle_pkg.sv
      - unit_if.sv
      - unit_slot.sv
      - unit_spawner.sv
      - battle_resolver.sv
      - wallet.sv
      - battle_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_battle_top.sv
